// File: Makefile
VERILATOR  ?= verilator
TOP        := wb_system_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/wb_dmem.sv
`timescale 1ns/1ps
`include "wb_sys_cfg.svh"

module wb_dmem
    import wb_sys_pkg::*;
(
    input  logic    wb_clk_i,
    input  logic    stb_i,
    input  logic    we_i,
    input  wb_sel_t sel_i,
    input  wb_adr_t adr_i,
    input  wb_dat_t dat_i,
    output wb_dat_t dat_o,
    output logic    ack_o
);

    wb_dat_t                  mem [`DMEM_DEPTH];
    logic [`DMEM_AWIDTH-1:0]  word_adr;
    wb_dat_t                  dat_q;
    logic                     ack_q;

    // Word index from the byte address
    assign word_adr = adr_i[`DMEM_AWIDTH+1:2];

    // Byte lane writes
    always_ff @(posedge wb_clk_i) begin
        if (stb_i && we_i) begin
            for (int b = 0; b < `WB_SWIDTH; b++) begin
                if (sel_i[b]) begin
                    mem[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

    // Read data and ack, one cycle after the strobe
    always_ff @(posedge wb_clk_i) begin
        ack_q <= stb_i;
        if (stb_i) begin
            dat_q <= mem[word_adr];
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

endmodule

// File: hdl/wb_gpio.sv
`timescale 1ns/1ps
`include "wb_sys_cfg.svh"

module wb_gpio
    import wb_sys_pkg::*;
(
    input  logic       wb_clk_i,
    input  logic       rst_n_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  wb_adr_t    adr_i,
    input  wb_dat_t    dat_i,
    input  gpio_t      gpio_i,
    output wb_dat_t    dat_o,
    output logic       ack_o,
    output gpio_t      gpio_o,
    output gpio_t      gpio_oe_o,
    output logic [7:0] ibase_o,
    output logic       soft_rst_req_o
);

    gpio_reg_e  reg_sel;
    gpio_t      gpio_meta;
    gpio_t      gpio_sync;
    gpio_t      dout_q;
    gpio_t      dir_q;
    logic [7:0] ibase_q;
    logic       soft_rst_q;
    wb_dat_t    dat_q;
    logic       ack_q;
    logic       wr_en;

    assign reg_sel = gpio_reg_e'(adr_i[3:2]);
    assign wr_en   = stb_i & we_i;

    // Two-flop input synchronizer
    always_ff @(posedge wb_clk_i) begin
        gpio_meta <= gpio_i;
        gpio_sync <= gpio_meta;
    end

    // --------------------
    // Control registers
    // --------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            dout_q     <= '0;
            dir_q      <= '0;
            ibase_q    <= '0;
            soft_rst_q <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            ack_q      <= stb_i;
            // Only a changed base asks for a reset
            soft_rst_q <= wr_en && reg_sel == IBASE && dat_i[7:0] != ibase_q;
            if (wr_en) begin
                case (reg_sel)
                    DOUT:    dout_q  <= dat_i[`GPIO_WIDTH-1:0];
                    DIR:     dir_q   <= dat_i[`GPIO_WIDTH-1:0];
                    IBASE:   ibase_q <= dat_i[7:0];
                    default: ;
                endcase
            end
        end
    end

    // Register read
    always_ff @(posedge wb_clk_i) begin
        if (stb_i) begin
            case (reg_sel)
                DOUT:    dat_q <= wb_dat_t'(dout_q);
                DIR:     dat_q <= wb_dat_t'(dir_q);
                DIN:     dat_q <= wb_dat_t'(gpio_sync);
                default: dat_q <= wb_dat_t'(ibase_q);
            endcase
        end
    end

    assign dat_o          = dat_q;
    assign ack_o          = ack_q;
    assign gpio_o         = dout_q;
    assign gpio_oe_o      = dir_q;
    assign ibase_o        = ibase_q;
    assign soft_rst_req_o = soft_rst_q;

endmodule

// File: hdl/wb_intercon.sv
`timescale 1ns/1ps
`include "wb_sys_cfg.svh"

module wb_intercon
    import wb_sys_pkg::*;
(
    input  logic    wb_clk_i,
    input  logic    rst_n_i,
    input  logic    cyc_i,
    input  logic    stb_i,
    input  wb_adr_t adr_i,
    input  wb_dat_t dmem_dat_i,
    input  wb_dat_t pic_dat_i,
    input  wb_dat_t gpio_dat_i,
    input  logic    dmem_ack_i,
    input  logic    pic_ack_i,
    input  logic    gpio_ack_i,
    output logic    dmem_stb_o,
    output logic    pic_stb_o,
    output logic    gpio_stb_o,
    output wb_dat_t dat_o,
    output logic    ack_o,
    output logic    err_o
);

    slave_e slv_dec;
    slave_e slv_q;
    logic   err_q;
    logic   req;

    // Address decode
    always_comb begin
        case (adr_i[`SLV_SEL_MSB:`SLV_SEL_LSB])
            4'd0:    slv_dec = DMEM;
            4'd1:    slv_dec = PIC;
            4'd2:    slv_dec = GPIO;
            default: slv_dec = NONE;
        endcase
    end

    // A request held through its own ack/err cycle is not taken again
    assign req = cyc_i & stb_i & ~(ack_o | err_o);

    assign dmem_stb_o = req & (slv_dec == DMEM);
    assign pic_stb_o  = req & (slv_dec == PIC);
    assign gpio_stb_o = req & (slv_dec == GPIO);

    // --------------------
    // Selection and error
    // --------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            slv_q <= NONE;
            err_q <= 1'b0;
        end else begin
            err_q <= req & (slv_dec == NONE);
            if (req) begin
                slv_q <= slv_dec;
            end
        end
    end

    assign err_o = err_q;

    // Return path from the slave that was addressed
    always_comb begin
        case (slv_q)
            DMEM: begin
                dat_o = dmem_dat_i;
                ack_o = dmem_ack_i;
            end
            PIC: begin
                dat_o = pic_dat_i;
                ack_o = pic_ack_i;
            end
            GPIO: begin
                dat_o = gpio_dat_i;
                ack_o = gpio_ack_i;
            end
            default: begin
                dat_o = '0;
                ack_o = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/wb_pic.sv
`timescale 1ns/1ps
`include "wb_sys_cfg.svh"

module wb_pic
    import wb_sys_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     rst_n_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  wb_adr_t  adr_i,
    input  wb_dat_t  dat_i,
    input  irq_vec_t irq_i,
    output wb_dat_t  dat_o,
    output logic     ack_o,
    output logic     irq_o
);

    pic_reg_e reg_sel;
    irq_vec_t irq_s;
    irq_vec_t irq_d;
    irq_vec_t irq_rise;
    irq_vec_t pending_q;
    irq_vec_t enable_q;
    irq_vec_t clr_mask;
    wb_dat_t  dat_q;
    logic     ack_q;

    assign reg_sel = pic_reg_e'(adr_i[3:2]);

    // Edge between two consecutive samples
    assign irq_rise = irq_s & ~irq_d;

    // Write-one-to-clear on PENDING
    assign clr_mask = (stb_i && we_i && reg_sel == PENDING) ? dat_i[`IRQ_COUNT-1:0] : '0;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            irq_s     <= '0;
            irq_d     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
            ack_q     <= 1'b0;
        end else begin
            irq_s     <= irq_i;
            irq_d     <= irq_s;
            // New edge wins over a clear in the same cycle
            pending_q <= (pending_q & ~clr_mask) | irq_rise;
            ack_q     <= stb_i;
            if (stb_i && we_i && reg_sel == ENABLE) begin
                enable_q <= dat_i[`IRQ_COUNT-1:0];
            end
        end
    end

    // --------------------
    // Register read
    // --------------------
    always_ff @(posedge wb_clk_i) begin
        if (stb_i) begin
            case (reg_sel)
                ENABLE:  dat_q <= wb_dat_t'(enable_q);
                PENDING: dat_q <= wb_dat_t'(pending_q);
                STATUS:  dat_q <= wb_dat_t'(pending_q & enable_q);
                default: dat_q <= '0;
            endcase
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;
    assign irq_o = |(pending_q & enable_q);

endmodule

// File: hdl/wb_reset_ctrl.sv
`timescale 1ns/1ps
`include "wb_sys_cfg.svh"

module wb_reset_ctrl (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    input  logic soft_rst_req_i,
    output logic sys_rst_n_o
);

    localparam int CNT_W = $clog2(`RST_HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    // Hold counter, reloaded by every soft request
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            hold_cnt <= '0;
        end else if (soft_rst_req_i) begin
            hold_cnt <= CNT_W'(`RST_HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Board reset passes straight through
    assign sys_rst_n_o = rst_n_i & (hold_cnt == '0);

endmodule

// File: hdl/wb_sys_pkg.sv
package wb_sys_pkg;

    `include "wb_sys_cfg.svh"

    // Bus vectors
    typedef logic [`WB_AWIDTH-1:0]  wb_adr_t;
    typedef logic [`WB_DWIDTH-1:0]  wb_dat_t;
    typedef logic [`WB_SWIDTH-1:0]  wb_sel_t;
    typedef logic [`IRQ_COUNT-1:0]  irq_vec_t;
    typedef logic [`GPIO_WIDTH-1:0] gpio_t;

    // Slave select, decoded from adr[15:12]
    typedef enum logic [1:0] {DMEM = 2'd0, PIC = 2'd1, GPIO = 2'd2, NONE = 2'd3} slave_e;

    // Interrupt controller registers at adr[3:2]
    typedef enum logic [1:0] {ENABLE = 2'd0, PENDING = 2'd1, STATUS = 2'd2, RESERVED = 2'd3} pic_reg_e;

    // GPIO registers at adr[3:2]
    typedef enum logic [1:0] {DOUT = 2'd0, DIR = 2'd1, DIN = 2'd2, IBASE = 2'd3} gpio_reg_e;

endpackage

// File: hdl/wb_system.sv
`timescale 1ns/1ps

module wb_system
    import wb_sys_pkg::*;
(
    input  logic       wb_clk_i,
    input  logic       rst_n_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  wb_sel_t    wb_sel_i,
    input  wb_adr_t    wb_adr_i,
    input  wb_dat_t    wb_dat_i,
    input  irq_vec_t   irq_i,
    input  gpio_t      gpio_i,
    output wb_dat_t    wb_dat_o,
    output logic       wb_ack_o,
    output logic       wb_err_o,
    output logic       irq_o,
    output gpio_t      gpio_o,
    output gpio_t      gpio_oe_o,
    output logic [7:0] ibase_o
);

    logic    sys_rst_n;
    logic    soft_rst_req;
    logic    dmem_stb;
    logic    pic_stb;
    logic    gpio_stb;
    logic    dmem_ack;
    logic    pic_ack;
    logic    gpio_ack;
    wb_dat_t dmem_dat;
    wb_dat_t pic_dat;
    wb_dat_t gpio_dat;

    // --------------------
    // Reset and bus
    // --------------------
    wb_reset_ctrl u_reset_ctrl (
        .wb_clk_i       ( wb_clk_i     ),
        .rst_n_i        ( rst_n_i      ),
        .soft_rst_req_i ( soft_rst_req ),
        .sys_rst_n_o    ( sys_rst_n    )
    );

    wb_intercon u_intercon (
        .wb_clk_i   ( wb_clk_i  ),
        .rst_n_i    ( sys_rst_n ),
        .cyc_i      ( wb_cyc_i  ),
        .stb_i      ( wb_stb_i  ),
        .adr_i      ( wb_adr_i  ),
        .dmem_dat_i ( dmem_dat  ),
        .pic_dat_i  ( pic_dat   ),
        .gpio_dat_i ( gpio_dat  ),
        .dmem_ack_i ( dmem_ack  ),
        .pic_ack_i  ( pic_ack   ),
        .gpio_ack_i ( gpio_ack  ),
        .dmem_stb_o ( dmem_stb  ),
        .pic_stb_o  ( pic_stb   ),
        .gpio_stb_o ( gpio_stb  ),
        .dat_o      ( wb_dat_o  ),
        .ack_o      ( wb_ack_o  ),
        .err_o      ( wb_err_o  )
    );

    // --------------------
    // Slaves
    // --------------------
    wb_dmem u_dmem (
        .wb_clk_i ( wb_clk_i ),
        .stb_i    ( dmem_stb ),
        .we_i     ( wb_we_i  ),
        .sel_i    ( wb_sel_i ),
        .adr_i    ( wb_adr_i ),
        .dat_i    ( wb_dat_i ),
        .dat_o    ( dmem_dat ),
        .ack_o    ( dmem_ack )
    );

    wb_pic u_pic (
        .wb_clk_i ( wb_clk_i  ),
        .rst_n_i  ( sys_rst_n ),
        .stb_i    ( pic_stb   ),
        .we_i     ( wb_we_i   ),
        .adr_i    ( wb_adr_i  ),
        .dat_i    ( wb_dat_i  ),
        .irq_i    ( irq_i     ),
        .dat_o    ( pic_dat   ),
        .ack_o    ( pic_ack   ),
        .irq_o    ( irq_o     )
    );

    // Board reset only, so the pin state and the base survive a soft reset
    wb_gpio u_gpio (
        .wb_clk_i       ( wb_clk_i     ),
        .rst_n_i        ( rst_n_i      ),
        .stb_i          ( gpio_stb     ),
        .we_i           ( wb_we_i      ),
        .adr_i          ( wb_adr_i     ),
        .dat_i          ( wb_dat_i     ),
        .gpio_i         ( gpio_i       ),
        .dat_o          ( gpio_dat     ),
        .ack_o          ( gpio_ack     ),
        .gpio_o         ( gpio_o       ),
        .gpio_oe_o      ( gpio_oe_o    ),
        .ibase_o        ( ibase_o      ),
        .soft_rst_req_o ( soft_rst_req )
    );

endmodule

// File: include/wb_sys_cfg.svh
`ifndef WB_SYS_CFG_SVH
`define WB_SYS_CFG_SVH

// Data bus geometry
`define WB_AWIDTH 16
`define WB_DWIDTH 32
`define WB_SWIDTH 4

// Peripheral sizes
`define IRQ_COUNT 8
`define GPIO_WIDTH 8

// Data memory, 256 x 32
`define DMEM_DEPTH 256
`define DMEM_AWIDTH 8

// System reset length after an IBASE change
`define RST_HOLD_CYCLES 4

// Address bits that pick the slave
`define SLV_SEL_MSB 15
`define SLV_SEL_LSB 12

`endif

// File: sources.f
+incdir+include
hdl/wb_sys_pkg.sv
hdl/wb_intercon.sv
hdl/wb_dmem.sv
hdl/wb_pic.sv
hdl/wb_gpio.sv
hdl/wb_reset_ctrl.sv
hdl/wb_system.sv
tb/wb_system_chk.sv
tb/wb_system_tb.sv

// File: tb/wb_system_chk.sv
`timescale 1ns/1ps
`include "wb_sys_cfg.svh"

module wb_system_chk (
    input logic clk_i,
    input logic rst_n_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic err_i,
    input logic soft_rst_req_i,
    input logic sys_rst_n_i
);

    // One response kind per transfer
    ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ack_i && err_i))
        else $error("ack and err high in the same cycle");

    ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else $error("ack high in two consecutive cycles");

    resp_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ack_i || err_i) |-> $past(cyc_i && stb_i))
        else $error("ack or err without a strobe in the cycle before");

    // --------------------
    // Soft reset hold
    // --------------------
    for (genvar k = 1; k <= `RST_HOLD_CYCLES; k++) begin : g_hold
        hold_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $past(soft_rst_req_i, k) |-> !sys_rst_n_i)
            else $error("sys_rst_n released too early after a soft request");
    end

endmodule

bind wb_system wb_system_chk u_chk (
    .clk_i          ( wb_clk_i     ),
    .rst_n_i        ( rst_n_i      ),
    .cyc_i          ( wb_cyc_i     ),
    .stb_i          ( wb_stb_i     ),
    .ack_i          ( wb_ack_o     ),
    .err_i          ( wb_err_o     ),
    .soft_rst_req_i ( soft_rst_req ),
    .sys_rst_n_i    ( sys_rst_n    )
);

// File: tb/wb_system_tb.sv
`timescale 1ns/1ps
`include "wb_sys_cfg.svh"

module wb_system_tb
    import wb_sys_pkg::*;
();

    localparam int HALF_PERIOD = 4;
    localparam int DRIVE_DLY   = 1;
    localparam int N_WORDS     = 64;
    // Tests run for about 500 cycles
    localparam int MAX_CYCLES  = 4000;

    logic       wb_clk_i;
    logic       rst_n_i;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    wb_sel_t    wb_sel_i;
    wb_adr_t    wb_adr_i;
    wb_dat_t    wb_dat_i;
    irq_vec_t   irq_i;
    gpio_t      gpio_i;
    wb_dat_t    wb_dat_o;
    logic       wb_ack_o;
    logic       wb_err_o;
    logic       irq_o;
    gpio_t      gpio_o;
    gpio_t      gpio_oe_o;
    logic [7:0] ibase_o;

    // Reference model state
    wb_dat_t    mem_m [`DMEM_DEPTH];
    irq_vec_t   enable_m;
    irq_vec_t   pending_m;
    gpio_t      dout_m;
    gpio_t      dir_m;
    gpio_t      din_m;
    logic [7:0] ibase_m;

    // Reads waiting for the compare process
    wb_adr_t    rd_adr_q [$];
    wb_dat_t    rd_exp_q [$];
    wb_dat_t    rd_act_q [$];
    int         reads_issued  = 0;
    int         reads_checked = 0;

    integer     seed;
    int         cycle_cnt;
    logic [7:0] adr_list [N_WORDS];

    wb_system wb_system_inst (
        .wb_clk_i  ( wb_clk_i  ),
        .rst_n_i   ( rst_n_i   ),
        .wb_cyc_i  ( wb_cyc_i  ),
        .wb_stb_i  ( wb_stb_i  ),
        .wb_we_i   ( wb_we_i   ),
        .wb_sel_i  ( wb_sel_i  ),
        .wb_adr_i  ( wb_adr_i  ),
        .wb_dat_i  ( wb_dat_i  ),
        .irq_i     ( irq_i     ),
        .gpio_i    ( gpio_i    ),
        .wb_dat_o  ( wb_dat_o  ),
        .wb_ack_o  ( wb_ack_o  ),
        .wb_err_o  ( wb_err_o  ),
        .irq_o     ( irq_o     ),
        .gpio_o    ( gpio_o    ),
        .gpio_oe_o ( gpio_oe_o ),
        .ibase_o   ( ibase_o   )
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #HALF_PERIOD wb_clk_i = ~wb_clk_i;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge wb_clk_i);
            cycle_cnt++;
            if (cycle_cnt >= MAX_CYCLES) begin
                $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
                abort_run();
            end
        end
    end

    // --------------------
    // Checks
    // --------------------
    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_dat(input string name, input wb_dat_t got, input wb_dat_t exp_dat);
        if (got !== exp_dat) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp_dat);
            abort_run();
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp_dat);
        if (got !== exp_dat) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp_dat);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_dat);
        if (got !== exp_dat) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp_dat);
            abort_run();
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic slave_e decode_slave(input wb_adr_t adr);
        case (adr[`SLV_SEL_MSB:`SLV_SEL_LSB])
            4'd0:    return DMEM;
            4'd1:    return PIC;
            4'd2:    return GPIO;
            default: return NONE;
        endcase
    endfunction

    function automatic wb_adr_t dmem_adr(input logic [7:0] idx);
        return {2'b00, DMEM, 2'b00, idx, 2'b00};
    endfunction

    function automatic wb_adr_t reg_adr(input slave_e slv, input logic [1:0] ofs);
        return {2'b00, slv, 8'h00, ofs, 2'b00};
    endfunction

    function automatic wb_dat_t ref_read(input wb_adr_t adr);
        case (decode_slave(adr))
            DMEM: return mem_m[adr[`DMEM_AWIDTH+1:2]];
            PIC: begin
                case (pic_reg_e'(adr[3:2]))
                    ENABLE:  return wb_dat_t'(enable_m);
                    PENDING: return wb_dat_t'(pending_m);
                    STATUS:  return wb_dat_t'(pending_m & enable_m);
                    default: return '0;
                endcase
            end
            GPIO: begin
                case (gpio_reg_e'(adr[3:2]))
                    DOUT:    return wb_dat_t'(dout_m);
                    DIR:     return wb_dat_t'(dir_m);
                    DIN:     return wb_dat_t'(din_m);
                    default: return wb_dat_t'(ibase_m);
                endcase
            end
            default: return '0;
        endcase
    endfunction

    task automatic model_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
        case (decode_slave(adr))
            DMEM: begin
                for (int b = 0; b < `WB_SWIDTH; b++) begin
                    if (sel[b]) begin
                        mem_m[adr[`DMEM_AWIDTH+1:2]][8*b +: 8] = dat[8*b +: 8];
                    end
                end
            end
            PIC: begin
                if (pic_reg_e'(adr[3:2]) == ENABLE) begin
                    enable_m = dat[`IRQ_COUNT-1:0];
                end else if (pic_reg_e'(adr[3:2]) == PENDING) begin
                    pending_m = pending_m & ~dat[`IRQ_COUNT-1:0];
                end
            end
            GPIO: begin
                case (gpio_reg_e'(adr[3:2]))
                    DOUT: dout_m = dat[`GPIO_WIDTH-1:0];
                    DIR:  dir_m  = dat[`GPIO_WIDTH-1:0];
                    IBASE: begin
                        // A new base resets the interrupt controller
                        if (dat[7:0] != ibase_m) begin
                            enable_m  = '0;
                            pending_m = '0;
                        end
                        ibase_m = dat[7:0];
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    endtask

    // --------------------
    // Bus master
    // --------------------
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge wb_clk_i);
            #DRIVE_DLY;
        end
    endtask

    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                             input wb_sel_t sel, output wb_dat_t rdat);
        logic exp_err;
        exp_err  = (decode_slave(adr) == NONE);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = sel;
        do begin
            @(posedge wb_clk_i);
            #DRIVE_DLY;
        end while (!(wb_ack_o || wb_err_o));
        check_bit("wb_ack_o", wb_ack_o, !exp_err);
        check_bit("wb_err_o", wb_err_o, exp_err);
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
        wb_dat_t rdat;
        bus_cycle(1'b1, adr, dat, sel, rdat);
        model_write(adr, dat, sel);
    endtask

    task automatic bus_read(input wb_adr_t adr);
        wb_dat_t rdat;
        bus_cycle(1'b0, adr, '0, '1, rdat);
        rd_adr_q.push_back(adr);
        rd_exp_q.push_back(ref_read(adr));
        rd_act_q.push_back(rdat);
        reads_issued++;
    endtask

    initial begin : compare_reads
        wb_adr_t adr;
        wb_dat_t exp_dat;
        wb_dat_t act_dat;
        forever begin
            @(posedge wb_clk_i);
            while (rd_act_q.size() > 0) begin
                adr     = rd_adr_q.pop_front();
                exp_dat = rd_exp_q.pop_front();
                act_dat = rd_act_q.pop_front();
                check_dat($sformatf("wb_dat_o at 0x%h", adr), act_dat, exp_dat);
                reads_checked++;
            end
        end
    end

    // --------------------
    // Tests
    // --------------------
    task automatic dmem_test();
        logic [31:0] rnd;
        logic [31:0] sel_rnd;
        // Full words first so no lane is left undefined
        for (int i = 0; i < N_WORDS; i++) begin
            rnd         = $random(seed);
            adr_list[i] = rnd[7:0];
            rnd         = $random(seed);
            bus_write(dmem_adr(adr_list[i]), rnd, 4'hf);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            rnd     = $random(seed);
            sel_rnd = $random(seed);
            bus_write(dmem_adr(adr_list[i]), rnd, sel_rnd[3:0]);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            bus_read(dmem_adr(adr_list[i]));
        end
    endtask

    task automatic unmapped_test();
        wb_adr_t bad_adr [3];
        bad_adr[0] = 16'h3000;
        bad_adr[1] = 16'h7ff4;
        bad_adr[2] = 16'hf008;
        for (int i = 0; i < 3; i++) begin
            bus_write(bad_adr[i], 32'hdead_beef, 4'hf);
            bus_read(bad_adr[i]);
        end
    endtask

    task automatic gpio_test();
        logic [31:0] rnd;
        rnd = $random(seed);
        bus_write(reg_adr(GPIO, DOUT), rnd, 4'hf);
        check_gpio("gpio_o", gpio_o, dout_m);
        rnd = $random(seed);
        bus_write(reg_adr(GPIO, DIR), rnd, 4'hf);
        check_gpio("gpio_oe_o", gpio_oe_o, dir_m);
        bus_read(reg_adr(GPIO, DOUT));
        bus_read(reg_adr(GPIO, DIR));
        bus_read(reg_adr(GPIO, IBASE));
        // Two synchronizer flops plus margin
        rnd    = $random(seed);
        gpio_i = rnd[7:0];
        din_m  = rnd[7:0];
        wait_cycles(4);
        bus_read(reg_adr(GPIO, DIN));
    endtask

    task automatic drive_irq(input irq_vec_t lines);
        pending_m = pending_m | (lines & ~irq_i);
        irq_i     = lines;
        wait_cycles(4);
    endtask

    task automatic irq_test();
        bus_write(reg_adr(PIC, ENABLE), 32'h35, 4'hf);
        check_bit("irq_o", irq_o, |(pending_m & enable_m));
        drive_irq(8'hc1);
        bus_read(reg_adr(PIC, PENDING));
        bus_read(reg_adr(PIC, STATUS));
        check_bit("irq_o", irq_o, |(pending_m & enable_m));
        // Clear bits 0 and 6 only, bit 7 stays pending
        bus_write(reg_adr(PIC, PENDING), 32'h41, 4'hf);
        check_bit("irq_o", irq_o, |(pending_m & enable_m));
        bus_read(reg_adr(PIC, PENDING));
        bus_read(reg_adr(PIC, STATUS));
        bus_read(reg_adr(PIC, RESERVED));
        bus_write(reg_adr(PIC, ENABLE), 32'h80, 4'hf);
        check_bit("irq_o", irq_o, |(pending_m & enable_m));
        bus_read(reg_adr(PIC, STATUS));
        // Lines low again before any soft reset
        drive_irq('0);
        bus_read(reg_adr(PIC, PENDING));
    endtask

    task automatic soft_reset_test();
        bus_write(reg_adr(GPIO, IBASE), 32'h5a, 4'hf);
        check_dat("ibase_o", wb_dat_t'(ibase_o), wb_dat_t'(ibase_m));
        wait_cycles(`RST_HOLD_CYCLES + 4);
        bus_read(reg_adr(PIC, ENABLE));
        bus_read(reg_adr(PIC, PENDING));
        check_bit("irq_o", irq_o, |(pending_m & enable_m));
        for (int i = 0; i < 8; i++) begin
            bus_read(dmem_adr(adr_list[i]));
        end
        bus_read(reg_adr(GPIO, DOUT));
        bus_read(reg_adr(GPIO, DIR));
        check_gpio("gpio_o", gpio_o, dout_m);
        check_gpio("gpio_oe_o", gpio_oe_o, dir_m);
        // Same base again, PIC must keep its enable
        bus_write(reg_adr(PIC, ENABLE), 32'hc3, 4'hf);
        bus_write(reg_adr(GPIO, IBASE), 32'h5a, 4'hf);
        wait_cycles(`RST_HOLD_CYCLES + 4);
        bus_read(reg_adr(PIC, ENABLE));
        check_dat("ibase_o", wb_dat_t'(ibase_o), wb_dat_t'(ibase_m));
    endtask

    initial begin
        seed      = 32'hf908fe1b;
        rst_n_i   = 1'b0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_sel_i  = '0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        irq_i     = '0;
        gpio_i    = '0;
        enable_m  = '0;
        pending_m = '0;
        dout_m    = '0;
        dir_m     = '0;
        din_m     = '0;
        ibase_m   = '0;
        repeat (4) @(posedge wb_clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        wait_cycles(1);

        // Idle state after reset
        check_bit("wb_ack_o", wb_ack_o, 1'b0);
        check_bit("wb_err_o", wb_err_o, 1'b0);
        check_bit("irq_o", irq_o, 1'b0);
        check_bit("soft_rst_req", wb_system_inst.soft_rst_req, 1'b0);
        check_gpio("gpio_o", gpio_o, '0);
        check_gpio("gpio_oe_o", gpio_oe_o, '0);
        check_dat("ibase_o", wb_dat_t'(ibase_o), '0);

        dmem_test();
        unmapped_test();
        gpio_test();
        irq_test();
        soft_reset_test();

        wait_cycles(2);
        if (reads_checked == reads_issued) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Only %0d of %0d reads were compared", reads_checked, reads_issued);
            abort_run();
        end
    end

endmodule
